//--- logic/soc_pkg.sv
package soc_pkg;

    // Bus widths
    localparam int DATA_W = 32;
    localparam int OFS_W  = 8;
    localparam int REG_W  = 2;
    localparam int ADDR_W = REG_W + OFS_W;

    // Copy engine register file
    localparam int RIDX_W = 2;
    localparam int LEN_W  = OFS_W + 1;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] haddr_t;
    typedef logic [RIDX_W-1:0] ridx_t;

    // Region code, top bits of a host address
    typedef enum logic [REG_W-1:0] {
        REG_DMA   = 2'd0,
        REG_RAM_A = 2'd1,
        REG_RAM_B = 2'd2,
        REG_NONE  = 2'd3
    } region_e;

    localparam ridx_t DMA_SRC  = 2'd0;
    localparam ridx_t DMA_DST  = 2'd1;
    localparam ridx_t DMA_LEN  = 2'd2;
    // Write bit 0 starts, read gives {done, busy}
    localparam ridx_t DMA_CTRL = 2'd3;

endpackage

//--- logic/host_decoder.sv
`timescale 1ns/1ps

module host_decoder
    import soc_pkg::*;
(
    input  logic             clk,
    input  logic             rst_i,
    input  logic             req_valid_i,
    input  logic             req_write_i,
    input  haddr_t           req_addr_i,
    input  word_t            req_wdata_i,
    input  logic             dma_busy_i,
    input  word_t            reg_rdata_i,
    input  word_t            host_ram_rdata_i,
    output logic             req_ready_o,
    output logic             rsp_valid_o,
    output word_t            rsp_rdata_o,
    output logic             rsp_err_o,
    output logic             reg_we_o,
    output logic             reg_re_o,
    output ridx_t            reg_idx_o,
    output word_t            reg_wdata_o,
    output logic             host_ram_en_o,
    output logic             host_ram_we_o,
    output logic             host_ram_sel_b_o,
    output logic [OFS_W-1:0] host_ram_idx_o,
    output word_t            host_ram_wdata_o
);

    region_e          req_region;
    logic             req_is_ram;
    logic             accept;

    logic             s1_valid;
    logic             s1_write;
    region_e          s1_region;
    logic [OFS_W-1:0] s1_ofs;
    word_t            s1_wdata;

    logic             s2_valid;
    logic             s2_write;
    region_e          s2_region;

    assign req_region = region_e'(req_addr_i[ADDR_W-1 -: REG_W]);
    assign req_is_ram = (req_region == REG_RAM_A) || (req_region == REG_RAM_B);

    // RAM traffic waits while the copy engine owns the RAMs
    assign req_ready_o = !(dma_busy_i && req_is_ram);
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_write  <= req_write_i;
        s1_region <= req_region;
        s1_ofs    <= req_addr_i[OFS_W-1:0];
        s1_wdata  <= req_wdata_i;
        s2_write  <= s1_write;
        s2_region <= s1_region;
    end

    // Offset only goes to the target, region bits are stripped
    assign reg_we_o    = s1_valid && s1_write && (s1_region == REG_DMA);
    assign reg_re_o    = s1_valid && !s1_write && (s1_region == REG_DMA);
    assign reg_idx_o   = s1_ofs[RIDX_W-1:0];
    assign reg_wdata_o = s1_wdata;

    assign host_ram_en_o    = s1_valid && ((s1_region == REG_RAM_A) || (s1_region == REG_RAM_B));
    assign host_ram_we_o    = s1_write;
    assign host_ram_sel_b_o = (s1_region == REG_RAM_B);
    assign host_ram_idx_o   = s1_ofs;
    assign host_ram_wdata_o = s1_wdata;

    assign rsp_valid_o = s2_valid;
    assign rsp_err_o   = s2_valid && (s2_region == REG_NONE);

    always_comb begin
        rsp_rdata_o = '0;
        if (s2_valid && !s2_write) begin
            case (s2_region)
                REG_DMA:              rsp_rdata_o = reg_rdata_i;
                REG_RAM_A, REG_RAM_B: rsp_rdata_o = host_ram_rdata_i;
                default:              rsp_rdata_o = '0;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst_i)
        rsp_valid_o |-> $past(req_valid_i && req_ready_o, 2))
        else $error("rsp_valid_o without a request accepted two cycles earlier");

endmodule

//--- logic/copy_dma.sv
`timescale 1ns/1ps

module copy_dma
    import soc_pkg::*;
#(
    parameter int RAM_DEPTH = 256
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         reg_we_i,
    input  logic                         reg_re_i,
    input  ridx_t                        reg_idx_i,
    input  word_t                        reg_wdata_i,
    input  word_t                        dma_ram_rdata_i,
    output word_t                        reg_rdata_o,
    output logic                         dma_busy_o,
    output logic                         irq_o,
    output logic                         dma_ram_en_o,
    output logic                         dma_ram_we_o,
    output logic                         dma_ram_sel_b_o,
    output logic [$clog2(RAM_DEPTH)-1:0] dma_ram_idx_o,
    output word_t                        dma_ram_wdata_o
);

    localparam int AW = $clog2(RAM_DEPTH);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_RD,
        S_CAP,
        S_WR
    } state_e;

    state_e           state_q;
    haddr_t           src_q;
    haddr_t           dst_q;
    logic [LEN_W-1:0] len_q;
    logic             done_q;

    // Working copies, loaded on start
    haddr_t           w_src;
    haddr_t           w_dst;
    logic [LEN_W-1:0] w_cnt;
    word_t            data_q;

    logic             ctrl_wr;
    logic             start;

    function automatic logic is_ram(input haddr_t a);
        region_e r;
        r = region_e'(a[ADDR_W-1 -: REG_W]);
        return (r == REG_RAM_A) || (r == REG_RAM_B);
    endfunction

    assign ctrl_wr = reg_we_i && (reg_idx_i == DMA_CTRL);
    assign start   = ctrl_wr && reg_wdata_i[0] && (state_q == S_IDLE);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            src_q <= '0;
            dst_q <= '0;
            len_q <= '0;
        end else if (reg_we_i) begin
            case (reg_idx_i)
                DMA_SRC: src_q <= reg_wdata_i[ADDR_W-1:0];
                DMA_DST: dst_q <= reg_wdata_i[ADDR_W-1:0];
                DMA_LEN: len_q <= reg_wdata_i[LEN_W-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reg_re_i) begin
            case (reg_idx_i)
                DMA_SRC: reg_rdata_o <= word_t'(src_q);
                DMA_DST: reg_rdata_o <= word_t'(dst_q);
                DMA_LEN: reg_rdata_o <= word_t'(len_q);
                default: reg_rdata_o <= word_t'({done_q, dma_busy_o});
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            done_q  <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                done_q <= 1'b0;
            end
            case (state_q)
                S_IDLE: begin
                    if (start) begin
                        state_q <= S_START;
                    end
                end
                // Empty copies and non-RAM regions finish here
                S_START: begin
                    if (w_cnt == '0 || !is_ram(w_src) || !is_ram(w_dst)) begin
                        state_q <= S_IDLE;
                        done_q  <= 1'b1;
                    end else begin
                        state_q <= S_RD;
                    end
                end
                S_RD:  state_q <= S_CAP;
                S_CAP: state_q <= S_WR;
                S_WR: begin
                    if (w_cnt == LEN_W'(1)) begin
                        state_q <= S_IDLE;
                        done_q  <= 1'b1;
                    end else begin
                        state_q <= S_RD;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            w_src <= src_q;
            w_dst <= dst_q;
            w_cnt <= len_q;
        end
        if (state_q == S_CAP) begin
            data_q <= dma_ram_rdata_i;
        end
        // Offsets wrap inside the RAM
        if (state_q == S_WR) begin
            w_src[AW-1:0] <= w_src[AW-1:0] + 1'b1;
            w_dst[AW-1:0] <= w_dst[AW-1:0] + 1'b1;
            w_cnt         <= w_cnt - 1'b1;
        end
    end

    assign dma_busy_o      = (state_q != S_IDLE);
    assign irq_o           = done_q;
    assign dma_ram_en_o    = (state_q == S_RD) || (state_q == S_WR);
    assign dma_ram_we_o    = (state_q == S_WR);
    assign dma_ram_sel_b_o = dma_ram_we_o ? (w_dst[ADDR_W-1 -: REG_W] == REG_RAM_B)
                                          : (w_src[ADDR_W-1 -: REG_W] == REG_RAM_B);
    assign dma_ram_idx_o   = dma_ram_we_o ? w_dst[AW-1:0] : w_src[AW-1:0];
    assign dma_ram_wdata_o = data_q;

    // One quiet cycle after idle lets the last host RAM access drain
    assert property (@(posedge clk) disable iff (rst_i)
        (state_q == S_IDLE) |=> !dma_ram_en_o)
        else $error("copy engine enabled a RAM straight out of idle");

endmodule

//--- logic/ram_arbiter.sv
`timescale 1ns/1ps

module ram_arbiter
    import soc_pkg::*;
#(
    parameter int RAM_DEPTH = 256
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         host_ram_en_i,
    input  logic                         host_ram_we_i,
    input  logic                         host_ram_sel_b_i,
    input  logic [OFS_W-1:0]             host_ram_idx_i,
    input  word_t                        host_ram_wdata_i,
    input  logic                         dma_ram_en_i,
    input  logic                         dma_ram_we_i,
    input  logic                         dma_ram_sel_b_i,
    input  logic [$clog2(RAM_DEPTH)-1:0] dma_ram_idx_i,
    input  word_t                        dma_ram_wdata_i,
    input  word_t                        a_rdata_i,
    input  word_t                        b_rdata_i,
    output word_t                        host_ram_rdata_o,
    output word_t                        dma_ram_rdata_o,
    output logic                         a_en_o,
    output logic                         a_we_o,
    output logic [$clog2(RAM_DEPTH)-1:0] a_idx_o,
    output word_t                        a_wdata_o,
    output logic                         b_en_o,
    output logic                         b_we_o,
    output logic [$clog2(RAM_DEPTH)-1:0] b_idx_o,
    output word_t                        b_wdata_o
);

    localparam int AW = $clog2(RAM_DEPTH);

    logic dma_a;
    logic dma_b;
    logic host_b_q;
    logic dma_b_q;

    // Copy engine wins any RAM it targets
    assign dma_a = dma_ram_en_i && !dma_ram_sel_b_i;
    assign dma_b = dma_ram_en_i && dma_ram_sel_b_i;

    assign a_en_o    = dma_a || (host_ram_en_i && !host_ram_sel_b_i);
    assign a_we_o    = dma_a ? dma_ram_we_i : host_ram_we_i;
    assign a_idx_o   = dma_a ? dma_ram_idx_i : host_ram_idx_i[AW-1:0];
    assign a_wdata_o = dma_a ? dma_ram_wdata_i : host_ram_wdata_i;

    assign b_en_o    = dma_b || (host_ram_en_i && host_ram_sel_b_i);
    assign b_we_o    = dma_b ? dma_ram_we_i : host_ram_we_i;
    assign b_idx_o   = dma_b ? dma_ram_idx_i : host_ram_idx_i[AW-1:0];
    assign b_wdata_o = dma_b ? dma_ram_wdata_i : host_ram_wdata_i;

    // Which RAM each side read last cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            host_b_q <= 1'b0;
            dma_b_q  <= 1'b0;
        end else begin
            host_b_q <= host_ram_sel_b_i;
            dma_b_q  <= dma_ram_sel_b_i;
        end
    end

    assign host_ram_rdata_o = host_b_q ? b_rdata_i : a_rdata_i;
    assign dma_ram_rdata_o  = dma_b_q ? b_rdata_i : a_rdata_i;

    assert property (@(posedge clk) disable iff (rst_i)
        !(host_ram_en_i && dma_ram_en_i && (host_ram_sel_b_i == dma_ram_sel_b_i)))
        else $error("host and copy engine hit the same RAM");

    assert property (@(posedge clk) disable iff (rst_i)
        host_ram_en_i |-> (host_ram_idx_i < RAM_DEPTH))
        else $error("host offset 0x%0h beyond RAM depth", host_ram_idx_i);

endmodule

//--- logic/periph_ram.sv
`timescale 1ns/1ps

module periph_ram
    import soc_pkg::*;
#(
    parameter int RAM_DEPTH = 256
) (
    input  logic                         clk,
    input  logic                         en_i,
    input  logic                         we_i,
    input  logic [$clog2(RAM_DEPTH)-1:0] idx_i,
    input  word_t                        wdata_i,
    output word_t                        rdata_o
);

    word_t mem [RAM_DEPTH];

    // Read returns the old word on a write
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[idx_i] <= wdata_i;
            end
            rdata_o <= mem[idx_i];
        end
    end

endmodule

//--- logic/vex_dma_soc.sv
`timescale 1ns/1ps

module vex_dma_soc
    import soc_pkg::*;
#(
    parameter int RAM_DEPTH = 256
) (
    input  logic   clk,
    input  logic   rst_i,
    input  logic   req_valid_i,
    input  logic   req_write_i,
    input  haddr_t req_addr_i,
    input  word_t  req_wdata_i,
    output logic   req_ready_o,
    output logic   rsp_valid_o,
    output word_t  rsp_rdata_o,
    output logic   rsp_err_o,
    output logic   irq_o
);

    localparam int AW = $clog2(RAM_DEPTH);

    logic             reg_we;
    logic             reg_re;
    ridx_t            reg_idx;
    word_t            reg_wdata;
    word_t            reg_rdata;
    logic             dma_busy;

    logic             host_ram_en;
    logic             host_ram_we;
    logic             host_ram_sel_b;
    logic [OFS_W-1:0] host_ram_idx;
    word_t            host_ram_wdata;
    word_t            host_ram_rdata;

    logic             dma_ram_en;
    logic             dma_ram_we;
    logic             dma_ram_sel_b;
    logic [AW-1:0]    dma_ram_idx;
    word_t            dma_ram_wdata;
    word_t            dma_ram_rdata;

    logic             a_en;
    logic             a_we;
    logic [AW-1:0]    a_idx;
    word_t            a_wdata;
    word_t            a_rdata;
    logic             b_en;
    logic             b_we;
    logic [AW-1:0]    b_idx;
    word_t            b_wdata;
    word_t            b_rdata;

    host_decoder u_dec (
        .clk              (clk),
        .rst_i            (rst_i),
        .req_valid_i      (req_valid_i),
        .req_write_i      (req_write_i),
        .req_addr_i       (req_addr_i),
        .req_wdata_i      (req_wdata_i),
        .dma_busy_i       (dma_busy),
        .reg_rdata_i      (reg_rdata),
        .host_ram_rdata_i (host_ram_rdata),
        .req_ready_o      (req_ready_o),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_rdata_o      (rsp_rdata_o),
        .rsp_err_o        (rsp_err_o),
        .reg_we_o         (reg_we),
        .reg_re_o         (reg_re),
        .reg_idx_o        (reg_idx),
        .reg_wdata_o      (reg_wdata),
        .host_ram_en_o    (host_ram_en),
        .host_ram_we_o    (host_ram_we),
        .host_ram_sel_b_o (host_ram_sel_b),
        .host_ram_idx_o   (host_ram_idx),
        .host_ram_wdata_o (host_ram_wdata)
    );

    copy_dma #(.RAM_DEPTH(RAM_DEPTH)) u_dma (
        .clk             (clk),
        .rst_i           (rst_i),
        .reg_we_i        (reg_we),
        .reg_re_i        (reg_re),
        .reg_idx_i       (reg_idx),
        .reg_wdata_i     (reg_wdata),
        .dma_ram_rdata_i (dma_ram_rdata),
        .reg_rdata_o     (reg_rdata),
        .dma_busy_o      (dma_busy),
        .irq_o           (irq_o),
        .dma_ram_en_o    (dma_ram_en),
        .dma_ram_we_o    (dma_ram_we),
        .dma_ram_sel_b_o (dma_ram_sel_b),
        .dma_ram_idx_o   (dma_ram_idx),
        .dma_ram_wdata_o (dma_ram_wdata)
    );

    ram_arbiter #(.RAM_DEPTH(RAM_DEPTH)) u_arb (
        .clk              (clk),
        .rst_i            (rst_i),
        .host_ram_en_i    (host_ram_en),
        .host_ram_we_i    (host_ram_we),
        .host_ram_sel_b_i (host_ram_sel_b),
        .host_ram_idx_i   (host_ram_idx),
        .host_ram_wdata_i (host_ram_wdata),
        .dma_ram_en_i     (dma_ram_en),
        .dma_ram_we_i     (dma_ram_we),
        .dma_ram_sel_b_i  (dma_ram_sel_b),
        .dma_ram_idx_i    (dma_ram_idx),
        .dma_ram_wdata_i  (dma_ram_wdata),
        .a_rdata_i        (a_rdata),
        .b_rdata_i        (b_rdata),
        .host_ram_rdata_o (host_ram_rdata),
        .dma_ram_rdata_o  (dma_ram_rdata),
        .a_en_o           (a_en),
        .a_we_o           (a_we),
        .a_idx_o          (a_idx),
        .a_wdata_o        (a_wdata),
        .b_en_o           (b_en),
        .b_we_o           (b_we),
        .b_idx_o          (b_idx),
        .b_wdata_o        (b_wdata)
    );

    periph_ram #(.RAM_DEPTH(RAM_DEPTH)) u_ram_a (
        .clk     (clk),
        .en_i    (a_en),
        .we_i    (a_we),
        .idx_i   (a_idx),
        .wdata_i (a_wdata),
        .rdata_o (a_rdata)
    );

    periph_ram #(.RAM_DEPTH(RAM_DEPTH)) u_ram_b (
        .clk     (clk),
        .en_i    (b_en),
        .we_i    (b_we),
        .idx_i   (b_idx),
        .wdata_i (b_wdata),
        .rdata_o (b_rdata)
    );

endmodule

//--- verification/vex_dma_soc_tb.sv
`timescale 1ns/1ps

module vex_dma_soc_tb
    import soc_pkg::*;
();

    localparam int QTR        = 25;
    localparam int READY_TMO  = 200;
    localparam int RSP_TMO    = 10;
    localparam int POLL_TRIES = 100;

    logic   clk;
    logic   rst_i;
    logic   req_valid_i;
    logic   req_write_i;
    haddr_t req_addr_i;
    word_t  req_wdata_i;
    logic   req_ready_o;
    logic   rsp_valid_o;
    word_t  rsp_rdata_o;
    logic   rsp_err_o;
    logic   irq_o;

    int errors;
    int timeouts;
    int n_cases;

    vex_dma_soc #(.RAM_DEPTH(256)) i_vex_dma_soc (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o),
        .irq_o       (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // Called on a falling edge, returns on the falling edge that shows the response
    task automatic do_request(input logic wr, input haddr_t addr, input word_t wdata,
                              input logic expect_stall, output word_t rdata, output logic err);
        int   waited;
        int   lat;
        logic accepted;
        rdata       = '0;
        err         = 1'b0;
        req_valid_i = 1'b1;
        req_write_i = wr;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        // Sample ready mid-cycle, away from both edges
        #(QTR);
        if (expect_stall) begin
            check_value("req_ready_o", word_t'(req_ready_o), 32'd0);
        end
        waited = 0;
        while (!req_ready_o && waited < READY_TMO) begin
            @(negedge clk);
            #(QTR);
            waited++;
        end
        accepted = req_ready_o;
        assert (accepted) else begin
            timeouts++;
            $display("Timed out waiting for req_ready_o on address 0x%03h", addr);
        end
        @(negedge clk);
        req_valid_i = 1'b0;
        if (accepted) begin
            lat = 1;
            while (!rsp_valid_o && lat < RSP_TMO) begin
                @(negedge clk);
                lat++;
            end
            assert (rsp_valid_o) else begin
                timeouts++;
                $display("Timed out waiting for a response on address 0x%03h", addr);
            end
            check_value("response latency", word_t'(lat), 32'd2);
            rdata = rsp_rdata_o;
            err   = rsp_err_o;
        end
    endtask

    task automatic run_case(input byte op, input haddr_t addr, input word_t wdata,
                            input word_t exp);
        word_t rdata;
        logic  err;
        int    tries;
        case (op)
            "W": begin
                do_request(1'b1, addr, wdata, 1'b0, rdata, err);
                check_value("rsp_err_o", word_t'(err), 32'd0);
                // Any CTRL write clears done, and bit 0 clear starts nothing
                if (addr == haddr_t'(DMA_CTRL) && !wdata[0]) begin
                    check_value("irq_o", word_t'(irq_o), 32'd0);
                end
            end
            "R": begin
                do_request(1'b0, addr, '0, wdata[0], rdata, err);
                check_value("rsp_err_o", word_t'(err), 32'd0);
                check_value("rsp_rdata_o", rdata, exp);
            end
            "P": begin
                tries = 0;
                rdata = '0;
                // Status bit 1 is done
                while (!rdata[1] && tries < POLL_TRIES && timeouts == 0) begin
                    do_request(1'b0, addr, '0, 1'b0, rdata, err);
                    tries++;
                end
                assert (rdata[1] === 1'b1) else begin
                    timeouts++;
                    $display("Timed out polling the status register for done");
                end
                check_value("status", rdata, exp);
                check_value("irq_o", word_t'(irq_o), 32'd1);
            end
            "X": begin
                do_request(1'b1, addr, wdata, 1'b0, rdata, err);
                check_value("rsp_err_o", word_t'(err), 32'd1);
                do_request(1'b0, addr, '0, 1'b0, rdata, err);
                check_value("rsp_err_o", word_t'(err), 32'd1);
                check_value("rsp_rdata_o", rdata, exp);
            end
            default: begin
                errors++;
                $display("Unknown operation '%c' in the case file", op);
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          code;
        string       line;
        byte         op;
        logic [31:0] addr_v;
        logic [31:0] wdata_v;
        logic [31:0] exp_v;
        void'($urandom(32'h6f63_f5c6));
        errors      = 0;
        timeouts    = 0;
        n_cases     = 0;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);

        check_value("req_ready_o", word_t'(req_ready_o), 32'd1);
        check_value("rsp_valid_o", word_t'(rsp_valid_o), 32'd0);
        check_value("rsp_err_o", word_t'(rsp_err_o), 32'd0);
        check_value("irq_o", word_t'(irq_o), 32'd0);

        fd = $fopen("verification/soc_cases.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("Could not open the case file verification/soc_cases.txt");
        end
        while (fd != 0 && !$feof(fd) && timeouts == 0) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0) begin
                // Comment and blank lines do not parse into four fields
                code = $sscanf(line, "%c %h %h %h", op, addr_v, wdata_v, exp_v);
                if (code == 4) begin
                    n_cases++;
                    run_case(op, addr_v[ADDR_W-1:0], wdata_v, exp_v);
                    repeat ($urandom_range(3)) @(negedge clk);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Cases: %0d, errors: %0d, timeouts: %0d", n_cases, errors, timeouts);
        if (errors == 0 && timeouts == 0 && n_cases > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verification/soc_cases.txt
# op addr wdata expected, all hex; R takes wdata bit 0 as expect req_ready_o low at first
# W write, R read and compare, P poll status until done, X unmapped write then read
W 110 a5a50001 00000000
W 210 5a5a0002 00000000
R 110 00000000 a5a50001
R 210 00000000 5a5a0002
W 1fe 11110000 00000000
W 1ff 22220001 00000000
W 100 33330002 00000000
W 101 44440003 00000000
W 23f dead003f 00000000
W 244 beef0044 00000000
W 245 66660005 00000000
W 000 000001fe 00000000
W 001 00000240 00000000
W 002 00000004 00000000
R 000 00000000 000001fe
R 001 00000000 00000240
R 002 00000000 00000004
R 003 00000000 00000000
W 003 00000001 00000000
P 003 00000000 00000002
R 240 00000000 11110000
R 241 00000000 22220001
R 242 00000000 33330002
R 243 00000000 44440003
R 23f 00000000 dead003f
R 244 00000000 beef0044
W 003 00000000 00000000
R 003 00000000 00000000
W 000 00000240 00000000
W 001 00000180 00000000
W 002 00000006 00000000
W 003 00000001 00000000
R 003 00000000 00000001
R 185 00000001 66660005
P 003 00000000 00000002
R 180 00000000 11110000
R 184 00000000 beef0044
W 003 00000000 00000000
W 105 cafe0105 00000000
W 205 f00d0205 00000000
X 305 12345678 00000000
R 105 00000000 cafe0105
R 205 00000000 f00d0205

//--- vex_dma_soc.f
logic/soc_pkg.sv
logic/host_decoder.sv
logic/copy_dma.sv
logic/ram_arbiter.sv
logic/periph_ram.sv
logic/vex_dma_soc.sv
verification/vex_dma_soc_tb.sv

//--- Makefile
TOP = vex_dma_soc_tb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vex_dma_soc.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f vex_dma_soc.f --top-module vex_dma_soc

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
